// File: Bender.yml
package:
  name: dispatch

sources:
  - files:
      - source/dispatch_pkg.sv
      - source/reg_status.sv
      - source/rob_alloc.sv
      - source/dispatcher.sv
      - source/issue_queue.sv
      - source/dispatch_top.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/dispatch_assert.sv
      - verification/tb_dispatch_top.sv

// File: source/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    localparam int data_len    = 32;
    localparam int reg_len     = 5;
    localparam int rob_depth   = 8;
    localparam int rob_len     = 3;
    localparam int queue_depth = 4;
    localparam int queue_len   = 2;

    // loads and stores must stay contiguous, op_lb .. op_sw
    typedef enum logic [5:0] {
        op_nop, op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor,
        op_srl, op_sra, op_or, op_and
    } op_t;

    typedef struct packed {
        op_t                 op;
        logic [data_len-1:0] v1;
        logic [data_len-1:0] v2;
        logic                q1_valid;
        logic [rob_len-1:0]  q1;
        logic                q2_valid;
        logic [rob_len-1:0]  q2;
        logic [data_len-1:0] pc;
        logic [data_len-1:0] imm;
        logic [rob_len-1:0]  rob_id;
    } rs_entry_t;

    typedef struct packed {
        op_t                 op;
        logic [data_len-1:0] v1;
        logic [data_len-1:0] v2;
        logic                q1_valid;
        logic [rob_len-1:0]  q1;
        logic                q2_valid;
        logic [rob_len-1:0]  q2;
        logic [data_len-1:0] imm;
        logic [rob_len-1:0]  rob_id;
    } lsb_entry_t;

endpackage

`default_nettype wire

// File: source/dispatch_top.sv
`default_nettype none

module dispatch_top import dispatch_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                inst_valid,
    output logic                     inst_ready,
    input  wire logic [data_len-1:0] pc,
    input  wire op_t                 op,
    input  wire logic [reg_len-1:0]  rd,
    input  wire logic [reg_len-1:0]  rs1,
    input  wire logic [reg_len-1:0]  rs2,
    input  wire logic [data_len-1:0] imm,
    input  wire logic                cdb_valid,
    input  wire logic [rob_len-1:0]  cdb_tag,
    input  wire logic [data_len-1:0] cdb_value,
    output logic                     rs_valid,
    output rs_entry_t                rs_entry,
    input  wire logic                rs_pop,
    output logic                     lsb_valid,
    output lsb_entry_t               lsb_entry,
    input  wire logic                lsb_pop,
    output logic                     commit_valid,
    output logic      [reg_len-1:0]  commit_rd,
    output logic      [rob_len-1:0]  commit_tag,
    output logic      [data_len-1:0] commit_value
);

    logic [reg_len-1:0]  rd_addr1, rd_addr2;
    logic [data_len-1:0] val1, val2;
    logic                tag1_valid, tag2_valid;
    logic [rob_len-1:0]  tag1, tag2;
    logic                alloc_en;
    logic [reg_len-1:0]  alloc_rd;
    logic [data_len-1:0] alloc_pc;
    logic [rob_len-1:0]  alloc_tag;
    logic                rob_full;
    logic [rob_len-1:0]  q1, q2;
    logic                q1_ready, q2_ready;
    logic [data_len-1:0] q1_value, q2_value;
    logic                rename_en;
    logic [reg_len-1:0]  rename_rd;
    logic [rob_len-1:0]  rename_tag;
    logic                rs_push, lsb_push;
    logic                rs_full, lsb_full;
    rs_entry_t           rs_push_entry;
    lsb_entry_t          lsb_push_entry;

    dispatcher dispatcher_inst (
        .clk, .rst_n, .inst_valid, .inst_ready, .pc, .op, .rd, .rs1, .rs2, .imm,
        .rd_addr1, .rd_addr2, .val1, .val2, .tag1_valid, .tag2_valid, .tag1, .tag2,
        .alloc_en, .alloc_rd, .alloc_pc, .alloc_tag, .rob_full,
        .q1, .q2, .q1_ready, .q1_value, .q2_ready, .q2_value,
        .cdb_valid, .cdb_tag, .cdb_value, .rename_en, .rename_rd, .rename_tag,
        .rs_push, .rs_entry(rs_push_entry), .rs_full,
        .lsb_push, .lsb_entry(lsb_push_entry), .lsb_full
    );

    reg_status reg_status_inst (
        .clk, .rst_n, .rd_addr1, .rd_addr2, .val1, .val2,
        .tag1_valid, .tag1, .tag2_valid, .tag2, .rename_en, .rename_rd, .rename_tag,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    rob_alloc rob_alloc_inst (
        .clk, .rst_n, .alloc_en, .alloc_rd, .alloc_pc, .alloc_tag, .full(rob_full),
        .q1, .q2, .q1_ready, .q1_value, .q2_ready, .q2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    issue_queue #(.payload_t(rs_entry_t)) rs_queue (
        .clk, .rst_n, .push(rs_push), .entry(rs_push_entry), .full(rs_full),
        .valid(rs_valid), .head(rs_entry), .pop(rs_pop)
    );

    issue_queue #(.payload_t(lsb_entry_t)) lsb_queue (
        .clk, .rst_n, .push(lsb_push), .entry(lsb_push_entry), .full(lsb_full),
        .valid(lsb_valid), .head(lsb_entry), .pop(lsb_pop)
    );

endmodule

`default_nettype wire

// File: source/dispatcher.sv
`default_nettype none

module dispatcher import dispatch_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                inst_valid,
    output logic                     inst_ready,
    input  wire logic [data_len-1:0] pc,
    input  wire op_t                 op,
    input  wire logic [reg_len-1:0]  rd,
    input  wire logic [reg_len-1:0]  rs1,
    input  wire logic [reg_len-1:0]  rs2,
    input  wire logic [data_len-1:0] imm,
    output logic      [reg_len-1:0]  rd_addr1,
    output logic      [reg_len-1:0]  rd_addr2,
    input  wire logic [data_len-1:0] val1,
    input  wire logic [data_len-1:0] val2,
    input  wire logic                tag1_valid,
    input  wire logic                tag2_valid,
    input  wire logic [rob_len-1:0]  tag1,
    input  wire logic [rob_len-1:0]  tag2,
    output logic                     alloc_en,
    output logic      [reg_len-1:0]  alloc_rd,
    output logic      [data_len-1:0] alloc_pc,
    input  wire logic [rob_len-1:0]  alloc_tag,
    input  wire logic                rob_full,
    output logic      [rob_len-1:0]  q1,
    output logic      [rob_len-1:0]  q2,
    input  wire logic                q1_ready,
    input  wire logic [data_len-1:0] q1_value,
    input  wire logic                q2_ready,
    input  wire logic [data_len-1:0] q2_value,
    input  wire logic                cdb_valid,
    input  wire logic [rob_len-1:0]  cdb_tag,
    input  wire logic [data_len-1:0] cdb_value,
    output logic                     rename_en,
    output logic      [reg_len-1:0]  rename_rd,
    output logic      [rob_len-1:0]  rename_tag,
    output logic                     rs_push,
    output rs_entry_t                rs_entry,
    input  wire logic                rs_full,
    output logic                     lsb_push,
    output lsb_entry_t               lsb_entry,
    input  wire logic                lsb_full
);

    logic                busy;
    logic                accept;
    logic                is_mem;
    logic                is_nop;
    logic                done;
    op_t                 op_q;
    logic [reg_len-1:0]  rd_q;
    logic [data_len-1:0] pc_q;
    logic [data_len-1:0] imm_q;
    logic [rob_len-1:0]  tag_q;
    logic                p1, p2;
    logic [data_len-1:0] v1, v2;

    // still waiting on a producer after rob and cdb lookup
    function automatic logic pending(input logic tv, input logic [rob_len-1:0] tag,
                                     input logic rob_rdy, input logic bus_valid,
                                     input logic [rob_len-1:0] bus_tag);
        return tv && !rob_rdy && !(bus_valid && bus_tag == tag);
    endfunction

    function automatic logic [data_len-1:0] resolve(input logic tv,
                                                    input logic [data_len-1:0] reg_val,
                                                    input logic rob_rdy,
                                                    input logic [data_len-1:0] rob_val,
                                                    input logic bus_valid,
                                                    input logic [data_len-1:0] bus_value);
        if (!tv) begin
            return reg_val;
        end else if (rob_rdy) begin
            return rob_val;
        end else if (bus_valid) begin
            return bus_value;
        end
        return '0;
    endfunction

    // phase 1
    assign inst_ready = !busy && !rob_full && !rs_full && !lsb_full;
    assign accept     = inst_valid && inst_ready;
    assign alloc_en   = accept && (op != op_nop);
    assign alloc_rd   = rd;
    assign alloc_pc   = pc;

    // phase 2, holds while the target queue is full
    assign is_nop   = (op_q == op_nop);
    assign is_mem   = (op_q >= op_lb) && (op_q <= op_sw);
    assign rs_push  = busy && !is_nop && !is_mem && !rs_full;
    assign lsb_push = busy && !is_nop && is_mem && !lsb_full;
    assign done     = is_nop || rs_push || lsb_push;

    assign q1 = tag1;
    assign q2 = tag2;
    assign p1 = pending(tag1_valid, tag1, q1_ready, cdb_valid, cdb_tag);
    assign p2 = pending(tag2_valid, tag2, q2_ready, cdb_valid, cdb_tag);
    assign v1 = p1 ? '0 : resolve(tag1_valid, val1, q1_ready, q1_value, cdb_valid, cdb_value);
    assign v2 = p2 ? '0 : resolve(tag2_valid, val2, q2_ready, q2_value, cdb_valid, cdb_value);

    assign rename_en  = (rs_push || lsb_push) && (rd_q != '0);
    assign rename_rd  = rd_q;
    assign rename_tag = tag_q;

    assign rs_entry  = '{op: op_q, v1: v1, v2: v2, q1_valid: p1, q1: tag1, q2_valid: p2,
                         q2: tag2, pc: pc_q, imm: imm_q, rob_id: tag_q};
    assign lsb_entry = '{op: op_q, v1: v1, v2: v2, q1_valid: p1, q1: tag1, q2_valid: p2,
                         q2: tag2, imm: imm_q, rob_id: tag_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (busy && done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= op;
            rd_q     <= rd;
            pc_q     <= pc;
            imm_q    <= imm;
            tag_q    <= alloc_tag;
            rd_addr1 <= rs1;
            rd_addr2 <= rs2;
        end
    end

endmodule

`default_nettype wire

// File: source/issue_queue.sv
`default_nettype none

module issue_queue import dispatch_pkg::*; #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire payload_t entry,
    output logic          full,
    output logic          valid,
    output payload_t      head,
    input  wire logic     pop
);

    payload_t             mem [queue_depth];
    logic [queue_len-1:0] rd_ptr;
    logic [queue_len-1:0] wr_ptr;
    logic [queue_len:0]   count;
    logic                 do_push;
    logic                 do_pop;

    assign full    = (count == queue_depth);
    assign valid   = (count != '0);
    assign head    = mem[rd_ptr];
    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (queue_len + 1)'(do_push) - (queue_len + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry;
        end
    end

endmodule

`default_nettype wire

// File: source/reg_status.sv
`default_nettype none

module reg_status import dispatch_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [reg_len-1:0]  rd_addr1,
    input  wire logic [reg_len-1:0]  rd_addr2,
    output logic      [data_len-1:0] val1,
    output logic      [data_len-1:0] val2,
    output logic                     tag1_valid,
    output logic      [rob_len-1:0]  tag1,
    output logic                     tag2_valid,
    output logic      [rob_len-1:0]  tag2,
    input  wire logic                rename_en,
    input  wire logic [reg_len-1:0]  rename_rd,
    input  wire logic [rob_len-1:0]  rename_tag,
    input  wire logic                commit_valid,
    input  wire logic [reg_len-1:0]  commit_rd,
    input  wire logic [rob_len-1:0]  commit_tag,
    input  wire logic [data_len-1:0] commit_value
);

    logic [data_len-1:0] values   [32];
    logic [rob_len-1:0]  tags     [32];
    logic                renamed  [32];

    assign val1       = values[rd_addr1];
    assign val2       = values[rd_addr2];
    assign tag1_valid = renamed[rd_addr1];
    assign tag1       = tags[rd_addr1];
    assign tag2_valid = renamed[rd_addr2];
    assign tag2       = tags[rd_addr2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                values[i]  <= '0;
                tags[i]    <= '0;
                renamed[i] <= 1'b0;
            end
        end else begin
            // x0 stays zero and is never renamed
            if (commit_valid && commit_rd != '0) begin
                values[commit_rd] <= commit_value;
                if (renamed[commit_rd] && tags[commit_rd] == commit_tag) begin
                    renamed[commit_rd] <= 1'b0;
                end
            end
            // newer rename overrides the commit clear
            if (rename_en && rename_rd != '0) begin
                renamed[rename_rd] <= 1'b1;
                tags[rename_rd]    <= rename_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rob_alloc.sv
`default_nettype none

module rob_alloc import dispatch_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                alloc_en,
    input  wire logic [reg_len-1:0]  alloc_rd,
    input  wire logic [data_len-1:0] alloc_pc,
    output logic      [rob_len-1:0]  alloc_tag,
    output logic                     full,
    input  wire logic [rob_len-1:0]  q1,
    input  wire logic [rob_len-1:0]  q2,
    output logic                     q1_ready,
    output logic      [data_len-1:0] q1_value,
    output logic                     q2_ready,
    output logic      [data_len-1:0] q2_value,
    input  wire logic                cdb_valid,
    input  wire logic [rob_len-1:0]  cdb_tag,
    input  wire logic [data_len-1:0] cdb_value,
    output logic                     commit_valid,
    output logic      [reg_len-1:0]  commit_rd,
    output logic      [rob_len-1:0]  commit_tag,
    output logic      [data_len-1:0] commit_value
);

    logic [rob_len-1:0]  head;
    logic [rob_len-1:0]  tail;
    logic [rob_len:0]    count;
    logic                ready    [rob_depth];
    logic [data_len-1:0] value    [rob_depth];
    logic [reg_len-1:0]  dest     [rob_depth];
    logic                do_alloc;

    assign full      = (count == rob_depth);
    assign alloc_tag = tail;
    assign do_alloc  = alloc_en && !full;

    assign q1_ready = ready[q1];
    assign q1_value = value[q1];
    assign q2_ready = ready[q2];
    assign q2_value = value[q2];

    // head retires as soon as it holds a result
    assign commit_valid = (count != '0) && ready[head];
    assign commit_rd    = dest[head];
    assign commit_tag   = head;
    assign commit_value = value[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                ready[i] <= 1'b0;
            end
        end else begin
            if (cdb_valid) begin
                ready[cdb_tag] <= 1'b1;
            end
            if (do_alloc) begin
                ready[tail] <= 1'b0;
                tail        <= tail + 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + (rob_len + 1)'(do_alloc) - (rob_len + 1)'(commit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_valid) begin
            value[cdb_tag] <= cdb_value;
        end
        if (do_alloc) begin
            dest[tail] <= alloc_rd;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
source/dispatch_pkg.sv
source/reg_status.sv
source/rob_alloc.sv
source/dispatcher.sv
source/issue_queue.sv
source/dispatch_top.sv
verification/clk_gen.sv
verification/dispatch_assert.sv
verification/tb_dispatch_top.sv

// File: verification/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        forever #2 clk = ~clk;
    end

    // release on a falling edge, away from the active edge
    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/dispatch_assert.sv
`default_nettype none

module dispatch_assert (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic inst_valid,
    input wire logic inst_ready,
    input wire logic rs_push,
    input wire logic lsb_push,
    input wire logic rs_full,
    input wire logic lsb_full
);

    one_queue_per_push: assert property (@(posedge clk) disable iff (!rst_n)
        !(rs_push && lsb_push))
        else $error("rs_push and lsb_push high together");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(rs_push && rs_full) && !(lsb_push && lsb_full))
        else $error("push into a full issue queue");

    // two-phase controller, no back-to-back accept
    busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_valid && inst_ready) |=> !inst_ready)
        else $error("inst_ready high in the cycle after an acceptance");

endmodule

bind dispatcher dispatch_assert dispatch_assert_inst (
    .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst_ready(inst_ready),
    .rs_push(rs_push), .lsb_push(lsb_push), .rs_full(rs_full), .lsb_full(lsb_full)
);

`default_nettype wire

// File: verification/tb_dispatch_top.sv
`default_nettype none

module tb_dispatch_top import dispatch_pkg::*; ;

    localparam int num_rows = 24;

    // route: 0 none, 1 rs queue, 2 lsb queue; cdb tag -1 means no write
    typedef struct {
        op_t op;
        int  rd, rs1, rs2, route, pop_rs, pop_lsb, pre_cdb, post_cdb;
    } row_t;

    logic                clk, rst_n;
    logic                inst_valid, inst_ready;
    logic [data_len-1:0] pc, imm;
    op_t                 op;
    logic [reg_len-1:0]  rd, rs1, rs2;
    logic                cdb_valid;
    logic [rob_len-1:0]  cdb_tag;
    logic [data_len-1:0] cdb_value;
    logic                rs_valid, rs_pop, lsb_valid, lsb_pop;
    rs_entry_t           rs_entry;
    lsb_entry_t          lsb_entry;
    logic                commit_valid;
    logic [reg_len-1:0]  commit_rd;
    logic [rob_len-1:0]  commit_tag;
    logic [data_len-1:0] commit_value;

    row_t                rows [num_rows];
    logic [data_len-1:0] arch_val [32];
    logic                ren_v [32];
    logic [rob_len-1:0]  ren_tag [32];
    logic [reg_len-1:0]  rob_rd [rob_depth];
    logic                rob_busy [rob_depth];
    logic                rob_rdy [rob_depth];
    logic [data_len-1:0] rob_val [rob_depth];
    int                  rob_head, rob_tail, rob_cnt;
    rs_entry_t           exp_rs [$];
    lsb_entry_t          exp_lsb [$];
    logic [reg_len-1:0]  exp_crd [$];
    logic [rob_len-1:0]  exp_ctag [$];
    logic [data_len-1:0] exp_cval [$];
    int                  errors, checks, commits_seen, commits_exp;

    clk_gen clk_gen_inst (.clk, .rst_n);

    dispatch_top dispatch_top_inst (.*);

    task automatic fail_value(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic check_rs(input rs_entry_t got, input rs_entry_t exp);
        rs_entry_t g;
        g = got;
        if (!g.q1_valid) g.q1 = '0;
        if (!g.q2_valid) g.q2 = '0;
        checks++;
        if (g !== exp) fail_value($sformatf("rs entry got %p expected %p", got, exp));
    endtask

    task automatic check_lsb(input lsb_entry_t got, input lsb_entry_t exp);
        lsb_entry_t g;
        g = got;
        if (!g.q1_valid) g.q1 = '0;
        if (!g.q2_valid) g.q2 = '0;
        checks++;
        if (g !== exp) fail_value($sformatf("lsb entry got %p expected %p", got, exp));
    endtask

    task automatic check_commit(input logic [reg_len-1:0] got_rd,
                                input logic [rob_len-1:0] got_tag,
                                input logic [data_len-1:0] got_val,
                                input logic [reg_len-1:0] exp_rd,
                                input logic [rob_len-1:0] exp_tag,
                                input logic [data_len-1:0] exp_val);
        checks++;
        if (got_rd !== exp_rd || got_tag !== exp_tag || got_val !== exp_val) begin
            fail_value($sformatf("commit x%0d tag %0d=%h expected x%0d tag %0d=%h",
                                 got_rd, got_tag, got_val, exp_rd, exp_tag, exp_val));
        end
    endtask

    task automatic read_operand(input int r, output logic [data_len-1:0] v,
                                output logic qv, output logic [rob_len-1:0] q);
        v  = '0;
        qv = 1'b0;
        q  = '0;
        if (r != 0 && !ren_v[r]) begin
            v = arch_val[r];
        end else if (r != 0 && rob_rdy[ren_tag[r]]) begin
            v = rob_val[ren_tag[r]];
        end else if (r != 0) begin
            qv = 1'b1;
            q  = ren_tag[r];
        end
    endtask

    // in-order retirement of every ready head entry
    task automatic retire_ready();
        logic [reg_len-1:0] r;
        while (rob_cnt > 0 && rob_rdy[rob_head]) begin
            r = rob_rd[rob_head];
            exp_crd.push_back(r);
            exp_ctag.push_back(rob_head);
            exp_cval.push_back(rob_val[rob_head]);
            if (r != 0) begin
                arch_val[r] = rob_val[rob_head];
                if (ren_v[r] && ren_tag[r] == rob_head) ren_v[r] = 1'b0;
            end
            rob_busy[rob_head] = 1'b0;
            rob_rdy[rob_head]  = 1'b0;
            rob_head = (rob_head + 1) % rob_depth;
            rob_cnt--;
            commits_exp++;
        end
    endtask

    task automatic send_cdb(input int tag);
        logic [data_len-1:0] value;
        if (tag < 0 || !rob_busy[tag] || rob_rdy[tag]) return;
        value     = $urandom;
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = value;
        rob_rdy[tag] = 1'b1;
        rob_val[tag] = value;
        retire_ready();
        @(negedge clk);
        cdb_valid = 1'b0;
    endtask

    task automatic wait_commits();
        while (commits_seen < commits_exp) @(negedge clk);
    endtask

    task automatic pop_rs(input int n);
        for (int k = 0; k < n && exp_rs.size() > 0; k++) begin
            if (!rs_valid) begin
                errors++;
                $display("rs queue is empty while an entry is still expected");
            end else begin
                check_rs(rs_entry, exp_rs[0]);
            end
            void'(exp_rs.pop_front());
            rs_pop = 1'b1;
            @(negedge clk);
            rs_pop = 1'b0;
        end
    endtask

    task automatic pop_lsb(input int n);
        for (int k = 0; k < n && exp_lsb.size() > 0; k++) begin
            if (!lsb_valid) begin
                errors++;
                $display("lsb queue is empty while an entry is still expected");
            end else begin
                check_lsb(lsb_entry, exp_lsb[0]);
            end
            void'(exp_lsb.pop_front());
            lsb_pop = 1'b1;
            @(negedge clk);
            lsb_pop = 1'b0;
        end
    endtask

    function automatic logic can_dispatch();
        return rob_cnt < rob_depth && exp_rs.size() < queue_depth
               && exp_lsb.size() < queue_depth;
    endfunction

    task automatic run_row(input int i);
        row_t                r;
        logic [data_len-1:0] imm_v, v1, v2;
        logic                a, b;
        logic [rob_len-1:0]  qa, qb;
        int                  tag;
        r = rows[i];
        @(negedge clk);
        if (inst_ready !== can_dispatch()) begin
            fail_value($sformatf("inst_ready %b expected %b", inst_ready, can_dispatch()));
        end
        pop_rs(r.pop_rs);
        pop_lsb(r.pop_lsb);
        send_cdb(r.pre_cdb);
        wait_commits();
        if (!can_dispatch()) begin
            errors++;
            $display("row %0d cannot be dispatched, the pipeline is still stalled", i);
            return;
        end
        imm_v      = $urandom;
        op         = r.op;
        rd         = r.rd;
        rs1        = r.rs1;
        rs2        = r.rs2;
        imm        = imm_v;
        pc         = i * 4;
        inst_valid = 1'b1;
        while (!inst_ready) @(negedge clk);
        @(negedge clk);
        inst_valid = 1'b0;
        read_operand(r.rs1, v1, a, qa);
        read_operand(r.rs2, v2, b, qb);
        if (r.route != 0) begin
            tag = rob_tail;
            rob_busy[tag] = 1'b1;
            rob_rdy[tag]  = 1'b0;
            rob_rd[tag]   = r.rd;
            rob_tail = (rob_tail + 1) % rob_depth;
            rob_cnt++;
            if (r.rd != 0) begin
                ren_v[r.rd]   = 1'b1;
                ren_tag[r.rd] = tag;
            end
            if (r.route == 1) begin
                exp_rs.push_back('{op: r.op, v1: v1, v2: v2, q1_valid: a, q1: qa,
                                   q2_valid: b, q2: qb, pc: i * 4, imm: imm_v, rob_id: tag});
            end else begin
                exp_lsb.push_back('{op: r.op, v1: v1, v2: v2, q1_valid: a, q1: qa,
                                    q2_valid: b, q2: qb, imm: imm_v, rob_id: tag});
            end
        end
        // phase 2 push lands on this edge
        @(negedge clk);
        send_cdb(r.post_cdb);
        wait_commits();
        $display("row %0d %s done, errors so far %0d", i, r.op.name(), errors);
    endtask

    task automatic set_row(input int i, input op_t o, input int d, input int s1, input int s2,
                           input int route, input int prs, input int plsb,
                           input int pre, input int post);
        rows[i] = '{o, d, s1, s2, route, prs, plsb, pre, post};
    endtask

    always @(negedge clk) begin
        if (rst_n && commit_valid) begin
            if (exp_crd.size() == 0) begin
                errors++;
                $display("commit of x%0d seen while none was expected", commit_rd);
            end else begin
                check_commit(commit_rd, commit_tag, commit_value, exp_crd.pop_front(),
                             exp_ctag.pop_front(), exp_cval.pop_front());
            end
            commits_seen++;
        end
    end

    initial begin
        repeat (40 * num_rows + 100) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(32'hcd9ba456));
        inst_valid = 1'b0;
        op         = op_nop;
        rd         = '0;
        rs1        = '0;
        rs2        = '0;
        imm        = '0;
        pc         = '0;
        cdb_valid  = 1'b0;
        cdb_tag    = '0;
        cdb_value  = '0;
        rs_pop     = 1'b0;
        lsb_pop    = 1'b0;
        errors     = 0;
        checks     = 0;
        rob_head   = 0;
        rob_tail   = 0;
        rob_cnt    = 0;
        commits_seen = 0;
        commits_exp  = 0;
        for (int k = 0; k < 32; k++) begin
            arch_val[k] = '0;
            ren_v[k]    = 1'b0;
            ren_tag[k]  = '0;
        end
        for (int k = 0; k < rob_depth; k++) begin
            rob_busy[k] = 1'b0;
            rob_rdy[k]  = 1'b0;
        end
        set_row(0,  op_addi,  1,  0,  0,  1, 0, 0, -1, 0);
        set_row(1,  op_lw,    2,  1,  0,  2, 1, 1, -1, -1);
        set_row(2,  op_add,   3,  2,  1,  1, 1, 1, -1, 2);
        set_row(3,  op_nop,   9,  1,  2,  0, 1, 1, -1, -1);
        set_row(4,  op_sw,    0,  3,  2,  2, 1, 1, -1, 1);
        set_row(5,  op_addi,  4,  4,  0,  1, 1, 1, -1, 3);
        set_row(6,  op_addi,  5,  3,  0,  1, 1, 1, -1, 4);
        set_row(7,  op_addi,  5,  5,  0,  1, 1, 1, -1, 5);
        set_row(8,  op_add,   6,  5,  0,  1, 1, 1, -1, 6);
        set_row(9,  op_lbu,   7,  5,  0,  2, 1, 1, -1, 7);
        // no results returned, the reorder buffer fills
        set_row(10, op_add,   8,  7,  6,  1, 1, 1, -1, -1);
        set_row(11, op_sb,    0,  8,  7,  2, 1, 1, -1, -1);
        set_row(12, op_xori,  9,  8,  0,  1, 1, 1, -1, -1);
        set_row(13, op_lh,    10, 9,  0,  2, 1, 1, -1, -1);
        set_row(14, op_sub,   11, 10, 9,  1, 1, 1, -1, -1);
        set_row(15, op_sw,    0,  11, 10, 2, 1, 1, -1, -1);
        set_row(16, op_or,    12, 11, 12, 1, 1, 1, -1, -1);
        set_row(17, op_and,   13, 12, 7,  1, 1, 1, 0,  -1);
        // no pops, the rs queue fills
        set_row(18, op_slli,  14, 13, 0,  1, 1, 1, 1,  2);
        set_row(19, op_srli,  15, 14, 0,  1, 0, 0, -1, 3);
        set_row(20, op_addi,  16, 1,  0,  1, 0, 0, -1, 4);
        set_row(21, op_lui,   17, 0,  0,  1, 0, 0, -1, 5);
        set_row(22, op_beq,   0,  1,  2,  1, 1, 0, -1, 6);
        set_row(23, op_lw,    18, 0,  0,  2, 4, 1, -1, 7);
        @(posedge rst_n);
        @(negedge clk);
        checks++;
        if (rs_valid !== 1'b0 || lsb_valid !== 1'b0 || commit_valid !== 1'b0
            || inst_ready !== 1'b1) begin
            fail_value("outputs not in their reset state");
        end
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        for (int k = 0; k < rob_depth && rob_cnt > 0; k++) begin
            send_cdb(rob_head);
        end
        wait_commits();
        pop_rs(queue_depth);
        pop_lsb(queue_depth);
        @(negedge clk);
        checks++;
        if (rs_valid !== 1'b0 || lsb_valid !== 1'b0 || commit_valid !== 1'b0) begin
            fail_value("queues or commit not empty after draining");
        end
        $display("done: %0d checks, %0d commits, %0d errors", checks, commits_seen, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
